// ==== mem_bus_pkg.sv ====
package mem_bus_pkg;

  // one line per address, lines are a single word
  typedef logic [63:0] addr_t;

  // line payload
  typedef logic [63:0] word_t;

  // memory transaction tag
  // zero on the response means the request was refused
  // zero on the tag means no data this cycle
  typedef logic [3:0] mem_tag_t;

  // processor to memory command
  typedef enum logic [1:0] {
    bus_none  = 2'd0,
    bus_load  = 2'd1,
    bus_store = 2'd2
  } bus_cmd_e;

  // a request is taken in the cycle where the command is not bus_none
  // and the response is nonzero; the response value is the tag
  // that later comes back with the load data

endpackage

// ==== mshr_pkg.sv ====
package mshr_pkg;

  // kind of miss, decoded from the bus command
  typedef enum logic {
    kind_load  = 1'b0,
    kind_store = 1'b1
  } miss_kind_e;

  // life of one entry
  typedef enum logic [1:0] {
    st_waiting     = 2'd0,
    st_in_progress = 2'd1,
    st_done        = 2'd2
  } entry_state_e;

  // one miss from the cache, 130 bits
  typedef struct packed {
    mem_bus_pkg::addr_t    addr;
    mem_bus_pkg::word_t    data;
    mem_bus_pkg::bus_cmd_e command;
  } miss_req_t;

  // up to three misses in age order, oldest in slot 0
  typedef struct packed {
    logic [1:0]      count;
    miss_req_t [2:0] slot;
  } miss_group_t;

  // one queue entry
  typedef struct packed {
    logic                  valid;
    entry_state_e          state;
    mem_bus_pkg::bus_cmd_e command;
    mem_bus_pkg::mem_tag_t mem_tag;
    mem_bus_pkg::addr_t    addr;
    mem_bus_pkg::word_t    data;
  } mshr_entry_t;

endpackage

// ==== miss_order.sv ====
`timescale 1ns/1ps

module miss_order (
  input  logic                      clock,
  input  logic                      reset,
  input  logic [2:0]                miss_en,
  input  mshr_pkg::miss_req_t [2:0] miss_req,
  output mshr_pkg::miss_group_t     miss_group
);

  mshr_pkg::miss_group_t packed_group;

  // squeeze the enabled slots toward slot 0
  // a lower input slot is older in program order, so order is kept
  always_comb begin
    logic [1:0] n;
    n = '0;
    packed_group = '0;
    for (int i = 0; i < 3; i++) begin
      if (miss_en[i]) begin
        packed_group.slot[n] = miss_req[i];
        n = n + 2'd1;
      end
    end
    packed_group.count = n;
  end

  // count is the only control here
  always_ff @(posedge clock) begin
    if (reset) begin
      miss_group.count <= '0;
    end else begin
      miss_group.count <= packed_group.count;
    end
  end

  // slots past count are don't care downstream
  always_ff @(posedge clock) begin
    miss_group.slot <= packed_group.slot;
  end

endmodule

// ==== mshr_queue.sv ====
`timescale 1ns/1ps

module mshr_queue #(
  parameter int depth = 8
) (
  input  logic                  clock,
  input  logic                  reset,
  input  mshr_pkg::miss_group_t miss_group,
  input  mem_bus_pkg::addr_t    load_search_addr,
  output logic                  load_hit,
  output mem_bus_pkg::word_t    load_hit_data,
  input  logic                  store_search_en,
  input  mem_bus_pkg::addr_t    store_search_addr,
  input  mem_bus_pkg::word_t    store_search_data,
  output logic                  store_hit,
  output logic                  fill_en,
  output mem_bus_pkg::addr_t    fill_addr,
  output mem_bus_pkg::word_t    fill_data,
  output logic                  mshr_full,
  output logic                  mshr_empty,
  output mem_bus_pkg::bus_cmd_e proc2mem_command,
  output mem_bus_pkg::addr_t    proc2mem_addr,
  output mem_bus_pkg::word_t    proc2mem_data,
  input  mem_bus_pkg::mem_tag_t mem2proc_response,
  input  mem_bus_pkg::word_t    mem2proc_data,
  input  mem_bus_pkg::mem_tag_t mem2proc_tag
);

  localparam int idx_w = $clog2(depth);

  // pointers keep a wrap bit above the index
  typedef logic [idx_w:0]   ptr_t;
  typedef logic [idx_w-1:0] idx_t;
  typedef logic [idx_w+1:0] occ_t;

  // full once fewer than three entries would stay free
  localparam occ_t full_mark = occ_t'(depth - 3);

  mshr_pkg::mshr_entry_t [depth-1:0] entries;
  mshr_pkg::mshr_entry_t [depth-1:0] next_entries;
  mshr_pkg::miss_kind_e              kind [depth];

  ptr_t tail_ptr;
  ptr_t issue_ptr;
  ptr_t wb_ptr;
  idx_t issue_idx;
  idx_t wb_idx;
  idx_t merge_idx;
  ptr_t used;
  occ_t committed;

  logic             accept;
  logic             store_retire;
  logic             retire;
  logic [depth-1:0] tag_match;

  assign issue_idx = issue_ptr[idx_w-1:0];
  assign wb_idx    = wb_ptr[idx_w-1:0];

  always_comb begin
    for (int i = 0; i < depth; i++) begin
      kind[i] = (entries[i].command == mem_bus_pkg::bus_store) ? mshr_pkg::kind_store
                                                               : mshr_pkg::kind_load;
    end
  end

  // issue head, held steady until memory answers nonzero
  assign proc2mem_command = (issue_ptr != tail_ptr) ? entries[issue_idx].command
                                                    : mem_bus_pkg::bus_none;
  assign proc2mem_addr    = entries[issue_idx].addr;
  assign proc2mem_data    = entries[issue_idx].data;
  assign accept = (proc2mem_command != mem_bus_pkg::bus_none) && (mem2proc_response != '0);

  // only loads get data back
  always_comb begin
    for (int i = 0; i < depth; i++) begin
      tag_match[i] = entries[i].valid && (entries[i].state == mshr_pkg::st_in_progress) &&
                     (kind[i] == mshr_pkg::kind_load) && (mem2proc_tag != '0) &&
                     (entries[i].mem_tag == mem2proc_tag);
    end
  end

  // writeback head
  assign fill_en = entries[wb_idx].valid && (kind[wb_idx] == mshr_pkg::kind_load) &&
                   (entries[wb_idx].state == mshr_pkg::st_done);
  assign store_retire = entries[wb_idx].valid && (kind[wb_idx] == mshr_pkg::kind_store) &&
                        (entries[wb_idx].state != mshr_pkg::st_waiting);
  assign retire    = fill_en || store_retire;
  assign fill_addr = entries[wb_idx].addr;
  assign fill_data = entries[wb_idx].data;

  // lookups, oldest to newest so the newest match wins
  always_comb begin
    idx_t idx;
    load_hit      = 1'b0;
    load_hit_data = '0;
    store_hit     = 1'b0;
    merge_idx     = '0;
    for (int i = 0; i < depth; i++) begin
      idx = wb_idx + idx_t'(i);
      if (entries[idx].valid && (kind[idx] == mshr_pkg::kind_store)) begin
        if (entries[idx].addr == load_search_addr) begin
          load_hit      = 1'b1;
          load_hit_data = entries[idx].data;
        end
        // a store going out this cycle already carries its old data
        if (store_search_en && (entries[idx].addr == store_search_addr) &&
            (entries[idx].state == mshr_pkg::st_waiting) &&
            !(accept && (idx == issue_idx))) begin
          store_hit = 1'b1;
          merge_idx = idx;
        end
      end
    end
  end

  always_comb begin
    idx_t slot_idx;
    next_entries = entries;
    // allocate at the tail, slot 0 first
    for (int s = 0; s < 3; s++) begin
      slot_idx = tail_ptr[idx_w-1:0] + idx_t'(s);
      if (2'(s) < miss_group.count) begin
        next_entries[slot_idx].valid   = 1'b1;
        next_entries[slot_idx].state   = mshr_pkg::st_waiting;
        next_entries[slot_idx].command = miss_group.slot[s].command;
        next_entries[slot_idx].mem_tag = '0;
        next_entries[slot_idx].addr    = miss_group.slot[s].addr;
        next_entries[slot_idx].data    = miss_group.slot[s].data;
      end
    end
    if (accept) begin
      next_entries[issue_idx].state   = mshr_pkg::st_in_progress;
      next_entries[issue_idx].mem_tag = mem2proc_response;
    end
    for (int i = 0; i < depth; i++) begin
      if (tag_match[i]) begin
        next_entries[i].state = mshr_pkg::st_done;
        next_entries[i].data  = mem2proc_data;
      end
    end
    if (store_hit) begin
      next_entries[merge_idx].data = store_search_data;
    end
    if (retire) begin
      next_entries[wb_idx].valid = 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < depth; i++) begin
        entries[i].valid <= 1'b0;
      end
    end else begin
      entries <= next_entries;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      tail_ptr  <= '0;
      issue_ptr <= '0;
      wb_ptr    <= '0;
    end else begin
      tail_ptr  <= tail_ptr + ptr_t'(miss_group.count);
      issue_ptr <= issue_ptr + ptr_t'(accept);
      wb_ptr    <= wb_ptr + ptr_t'(retire);
    end
  end

  // occupancy counts the group still in flight from miss_order
  assign used       = tail_ptr - wb_ptr;
  assign committed  = occ_t'(used) + occ_t'(miss_group.count);
  assign mshr_full  = committed > full_mark;
  assign mshr_empty = (used == '0);

  // the cache keeps miss_en low while full, so nothing arrives next cycle
  a_no_group_after_full: assert property (
    @(posedge clock) disable iff (reset) mshr_full |=> (miss_group.count == '0));

  // memory keeps outstanding tags unique
  a_unique_tag: assert property (
    @(posedge clock) disable iff (reset) $onehot0(tag_match));

  a_wb_behind_issue: assert property (
    @(posedge clock) disable iff (reset) (ptr_t'(issue_ptr - wb_ptr) <= used));

endmodule

// ==== mshr_top.sv ====
`timescale 1ns/1ps

module mshr_top #(
  parameter int depth = 8
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic [2:0]                miss_en,
  input  mshr_pkg::miss_req_t [2:0] miss_req,
  input  mem_bus_pkg::addr_t        load_search_addr,
  output logic                      load_hit,
  output mem_bus_pkg::word_t        load_hit_data,
  input  logic                      store_search_en,
  input  mem_bus_pkg::addr_t        store_search_addr,
  input  mem_bus_pkg::word_t        store_search_data,
  output logic                      store_hit,
  output logic                      fill_en,
  output mem_bus_pkg::addr_t        fill_addr,
  output mem_bus_pkg::word_t        fill_data,
  output logic                      mshr_full,
  output logic                      mshr_empty,
  output mem_bus_pkg::bus_cmd_e     proc2mem_command,
  output mem_bus_pkg::addr_t        proc2mem_addr,
  output mem_bus_pkg::word_t        proc2mem_data,
  input  mem_bus_pkg::mem_tag_t     mem2proc_response,
  input  mem_bus_pkg::word_t        mem2proc_data,
  input  mem_bus_pkg::mem_tag_t     mem2proc_tag
);

  // ordered misses, one cycle behind the cache
  mshr_pkg::miss_group_t miss_group;

  miss_order order_stage (
    .clock      (clock),
    .reset      (reset),
    .miss_en    (miss_en),
    .miss_req   (miss_req),
    .miss_group (miss_group)
  );

  mshr_queue #(
    .depth (depth)
  ) queue_stage (
    .clock             (clock),
    .reset             (reset),
    .miss_group        (miss_group),
    .load_search_addr  (load_search_addr),
    .load_hit          (load_hit),
    .load_hit_data     (load_hit_data),
    .store_search_en   (store_search_en),
    .store_search_addr (store_search_addr),
    .store_search_data (store_search_data),
    .store_hit         (store_hit),
    .fill_en           (fill_en),
    .fill_addr         (fill_addr),
    .fill_data         (fill_data),
    .mshr_full         (mshr_full),
    .mshr_empty        (mshr_empty),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .proc2mem_data     (proc2mem_data),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag)
  );

endmodule

// ==== tb_mshr.sv ====
`timescale 1ns/1ps

module tb_mshr;

  localparam int period = 40;
  localparam int num_tests = 6;
  localparam int watch_cycles = 200 * num_tests + 2000;
  localparam mem_bus_pkg::word_t load_key = 64'h5a5a_0f0f_a5a5_f0f0;

  logic                      clock;
  logic                      reset;
  logic [2:0]                miss_en;
  mshr_pkg::miss_req_t [2:0] miss_req;
  mem_bus_pkg::addr_t        load_search_addr;
  logic                      load_hit;
  mem_bus_pkg::word_t        load_hit_data;
  logic                      store_search_en;
  mem_bus_pkg::addr_t        store_search_addr;
  mem_bus_pkg::word_t        store_search_data;
  logic                      store_hit;
  logic                      fill_en;
  mem_bus_pkg::addr_t        fill_addr;
  mem_bus_pkg::word_t        fill_data;
  logic                      mshr_full;
  logic                      mshr_empty;
  mem_bus_pkg::bus_cmd_e     proc2mem_command;
  mem_bus_pkg::addr_t        proc2mem_addr;
  mem_bus_pkg::word_t        proc2mem_data;
  mem_bus_pkg::mem_tag_t     mem2proc_response = '0;
  mem_bus_pkg::word_t        mem2proc_data = '0;
  mem_bus_pkg::mem_tag_t     mem2proc_tag = '0;

  // expected issue order and fill order
  mem_bus_pkg::bus_cmd_e exp_cmd [1024];
  mem_bus_pkg::addr_t    exp_addr [1024];
  mem_bus_pkg::word_t    exp_data [1024];
  mem_bus_pkg::addr_t    exp_fill [1024];
  logic [9:0]            issue_wr = '0;
  logic [9:0]            issue_rd = '0;
  logic [9:0]            fill_wr = '0;
  logic [9:0]            fill_rd = '0;
  mem_bus_pkg::bus_cmd_e head_cmd;
  mem_bus_pkg::addr_t    head_addr;
  mem_bus_pkg::word_t    head_data;
  mem_bus_pkg::addr_t    fill_head;
  logic                  accept_seen;

  logic                  lookup_check = 1'b0;
  logic                  exp_load_hit = 1'b0;
  mem_bus_pkg::word_t    exp_load_data = '0;
  logic                  exp_store_hit = 1'b0;

  int                    errors = 0;
  int                    test_start = 0;
  int                    tests_run = 0;
  int                    tests_failed = 0;
  logic                  mem_hold = 1'b0;
  int                    reject_level = 0;
  logic [31:0]           stim_rng = 32'h369bbe72;
  logic [31:0]           mem_rng = 32'h369bbe72;
  mem_bus_pkg::word_t    store_log [mem_bus_pkg::addr_t];

  mshr_top uut (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic void flag_mismatch(input string name, input logic [63:0] got,
                                        input logic [63:0] exp);
    errors++;
    $display("mismatch %s got %h expected %h", name, got, exp);
  endfunction

  function automatic void note_failure(input string what);
    errors++;
    $display("%s", what);
  endfunction

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  initial begin
    #(watch_cycles * period);
    $display("timeout: run did not finish within %0d cycles", watch_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

  assign accept_seen = (proc2mem_command != mem_bus_pkg::bus_none) && (mem2proc_response != '0);
  assign head_cmd    = exp_cmd[issue_rd];
  assign head_addr   = exp_addr[issue_rd];
  assign head_data   = exp_data[issue_rd];
  assign fill_head   = exp_fill[fill_rd];

  // scoreboard heads move after the edge that consumed them
  always @(posedge clock) begin
    if (!reset && accept_seen) begin
      issue_rd <= issue_rd + 10'd1;
    end
    if (!reset && fill_en) begin
      fill_rd <= fill_rd + 10'd1;
    end
  end

  a_issue_expected: assert property (@(posedge clock) disable iff (reset)
    accept_seen |-> (issue_rd < issue_wr))
    else note_failure("memory accepted a request that was never sent");
  a_issue_cmd: assert property (@(posedge clock) disable iff (reset)
    accept_seen |-> (proc2mem_command == head_cmd))
    else flag_mismatch("proc2mem_command", $sampled(proc2mem_command), $sampled(head_cmd));
  a_issue_addr: assert property (@(posedge clock) disable iff (reset)
    accept_seen |-> (proc2mem_addr == head_addr))
    else flag_mismatch("proc2mem_addr", $sampled(proc2mem_addr), $sampled(head_addr));
  a_issue_data: assert property (@(posedge clock) disable iff (reset)
    (accept_seen && proc2mem_command == mem_bus_pkg::bus_store) |-> (proc2mem_data == head_data))
    else flag_mismatch("proc2mem_data", $sampled(proc2mem_data), $sampled(head_data));
  // a refused request stays on the bus unchanged
  a_hold_stable: assert property (@(posedge clock) disable iff (reset)
    (proc2mem_command != mem_bus_pkg::bus_none && mem2proc_response == '0) |=>
    (proc2mem_command == $past(proc2mem_command) && proc2mem_addr == $past(proc2mem_addr)))
    else note_failure("request on the memory bus changed while refused");
  a_fill_expected: assert property (@(posedge clock) disable iff (reset)
    fill_en |-> (fill_rd < fill_wr))
    else note_failure("fill_en raised with no load miss outstanding");
  a_fill_addr: assert property (@(posedge clock) disable iff (reset)
    fill_en |-> (fill_addr == fill_head))
    else flag_mismatch("fill_addr", $sampled(fill_addr), $sampled(fill_head));
  a_fill_data: assert property (@(posedge clock) disable iff (reset)
    fill_en |-> (fill_data == (fill_head ^ load_key)))
    else flag_mismatch("fill_data", $sampled(fill_data), $sampled(fill_head) ^ load_key);
  a_load_hit: assert property (@(posedge clock) disable iff (reset)
    lookup_check |-> (load_hit == exp_load_hit))
    else flag_mismatch("load_hit", $sampled(load_hit), $sampled(exp_load_hit));
  a_load_data: assert property (@(posedge clock) disable iff (reset)
    (lookup_check && exp_load_hit) |-> (load_hit_data == exp_load_data))
    else flag_mismatch("load_hit_data", $sampled(load_hit_data), $sampled(exp_load_data));
  a_store_hit: assert property (@(posedge clock) disable iff (reset)
    store_search_en |-> (store_hit == exp_store_hit))
    else flag_mismatch("store_hit", $sampled(store_hit), $sampled(exp_store_hit));

  // memory with random accept gaps and shuffled load returns
  logic               busy [16];
  mem_bus_pkg::addr_t tag_addr [16];
  int                 ready_at [16];
  int                 mem_cycle = 0;

  always @(posedge clock) begin : memory_model
    logic                  in_reset;
    logic                  hold_now;
    int                    level_now;
    int                    n_ready;
    int                    pick;
    mem_bus_pkg::mem_tag_t ready_list [16];
    mem_bus_pkg::mem_tag_t ret_tag;
    mem_bus_pkg::mem_tag_t new_tag;
    in_reset  = reset;
    hold_now  = mem_hold;
    level_now = reject_level;
    #2;
    mem_cycle++;
    mem2proc_response = '0;
    mem2proc_tag      = '0;
    mem2proc_data     = '0;
    if (in_reset) begin
      for (int t = 0; t < 16; t++) begin
        busy[t] = 1'b0;
      end
    end else begin
      n_ready = 0;
      ret_tag = '0;
      for (int t = 1; t < 16; t++) begin
        if (busy[t] && mem_cycle >= ready_at[t]) begin
          ready_list[n_ready] = 4'(t);
          n_ready++;
        end
      end
      if (n_ready > 0) begin
        mem_rng       = lcg_next(mem_rng);
        pick          = int'(mem_rng[23:16]) % n_ready;
        ret_tag       = ready_list[pick];
        mem2proc_tag  = ret_tag;
        mem2proc_data = tag_addr[ret_tag] ^ load_key;
      end
      mem_rng = lcg_next(mem_rng);
      if (proc2mem_command != mem_bus_pkg::bus_none && !hold_now &&
          int'(mem_rng[18:16]) >= level_now) begin
        new_tag = '0;
        // lowest free tag
        for (int t = 15; t >= 1; t--) begin
          if (!busy[t] && 4'(t) != ret_tag) begin
            new_tag = 4'(t);
          end
        end
        mem2proc_response = new_tag;
        if (proc2mem_command == mem_bus_pkg::bus_load) begin
          busy[new_tag]     = 1'b1;
          tag_addr[new_tag] = proc2mem_addr;
          ready_at[new_tag] = mem_cycle + 1 + int'(mem_rng[26:24]);
        end else begin
          store_log[proc2mem_addr] = proc2mem_data;
        end
      end
      if (ret_tag != '0) begin
        busy[ret_tag] = 1'b0;
      end
    end
  end

  task automatic next_cycle;
    @(posedge clock);
    #2;
  endtask

  task automatic set_slot(input int i, input mem_bus_pkg::bus_cmd_e cmd,
                          input mem_bus_pkg::addr_t addr, input mem_bus_pkg::word_t data);
    miss_req[i].command = cmd;
    miss_req[i].addr    = addr;
    miss_req[i].data    = data;
  endtask

  // records enabled slots in program order, then raises miss_en for one cycle
  task automatic launch(input logic [2:0] en);
    for (int i = 0; i < 3; i++) begin
      if (en[i]) begin
        exp_cmd[issue_wr]  = miss_req[i].command;
        exp_addr[issue_wr] = miss_req[i].addr;
        exp_data[issue_wr] = miss_req[i].data;
        issue_wr           = issue_wr + 10'd1;
        if (miss_req[i].command == mem_bus_pkg::bus_load) begin
          exp_fill[fill_wr] = miss_req[i].addr;
          fill_wr           = fill_wr + 10'd1;
        end
      end
    end
    miss_en = en;
    next_cycle();
    miss_en = '0;
  endtask

  task automatic set_memory(input logic hold, input int level);
    @(negedge clock);
    mem_hold     = hold;
    reject_level = level;
    next_cycle();
  endtask

  task automatic drain(input int limit);
    int n;
    n = 0;
    repeat (2) next_cycle();
    while (!(mshr_empty && issue_rd == issue_wr && fill_rd == fill_wr) && n < limit) begin
      next_cycle();
      n++;
    end
    if (n >= limit) begin
      errors++;
      $display("queue did not drain within %0d cycles", limit);
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got == exp)
      else flag_mismatch(name, got, exp);
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != test_start) begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, errors - test_start);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
    test_start = errors;
  endtask

  initial begin
    int   n;
    int   store_idx;
    logic full_seen;
    reset             = 1'b1;
    miss_en           = '0;
    miss_req          = '0;
    load_search_addr  = '0;
    store_search_en   = 1'b0;
    store_search_addr = '0;
    store_search_data = '0;
    repeat (10) next_cycle();
    reset = 1'b0;

    check_value("proc2mem_command", 64'(proc2mem_command), 64'(mem_bus_pkg::bus_none));
    check_value("fill_en", 64'(fill_en), 64'd0);
    check_value("mshr_empty", 64'(mshr_empty), 64'd1);
    check_value("mshr_full", 64'(mshr_full), 64'd0);
    check_value("load_hit", 64'(load_hit), 64'd0);
    end_test("reset state");

    // slot order within a group and arrival order across groups under refusals
    set_memory(1'b0, 4);
    set_slot(0, mem_bus_pkg::bus_load, 64'h1000, '0);
    set_slot(1, mem_bus_pkg::bus_load, 64'h1040, '0);
    set_slot(2, mem_bus_pkg::bus_load, 64'h1080, '0);
    launch(3'b111);
    set_slot(0, mem_bus_pkg::bus_store, 64'h2000, 64'hdead_beef_0000_0001);
    set_slot(2, mem_bus_pkg::bus_load, 64'h20c0, '0);
    launch(3'b101);
    set_slot(1, mem_bus_pkg::bus_load, 64'h3000, '0);
    launch(3'b010);
    drain(150);
    end_test("issue order");

    set_memory(1'b0, 0);
    set_slot(0, mem_bus_pkg::bus_load, 64'h4000, '0);
    set_slot(1, mem_bus_pkg::bus_load, 64'h4040, '0);
    set_slot(2, mem_bus_pkg::bus_load, 64'h4080, '0);
    launch(3'b111);
    set_slot(0, mem_bus_pkg::bus_load, 64'h5000, '0);
    set_slot(1, mem_bus_pkg::bus_load, 64'h5040, '0);
    set_slot(2, mem_bus_pkg::bus_load, 64'h5080, '0);
    launch(3'b111);
    drain(150);
    end_test("out of order fills");

    // memory held so the store stays waiting
    set_memory(1'b1, 0);
    store_idx = int'(issue_wr);
    set_slot(0, mem_bus_pkg::bus_store, 64'h6000, 64'h1111_2222_3333_4444);
    set_slot(1, mem_bus_pkg::bus_load, 64'h7000, '0);
    launch(3'b011);
    n = 0;
    while (mshr_empty && n < 10) begin
      next_cycle();
      n++;
    end
    load_search_addr = 64'h6000;
    exp_load_hit     = 1'b1;
    exp_load_data    = 64'h1111_2222_3333_4444;
    lookup_check     = 1'b1;
    next_cycle();
    load_search_addr = 64'h6008;
    exp_load_hit     = 1'b0;
    next_cycle();
    lookup_check = 1'b0;
    end_test("load lookup");

    store_search_en   = 1'b1;
    store_search_addr = 64'h6000;
    store_search_data = 64'hcafe_f00d_0bad_c0de;
    exp_store_hit     = 1'b1;
    exp_data[store_idx] = 64'hcafe_f00d_0bad_c0de;
    next_cycle();
    // held only by a load entry
    store_search_addr = 64'h7000;
    exp_store_hit     = 1'b0;
    next_cycle();
    store_search_en = 1'b0;
    set_memory(1'b0, 2);
    drain(150);
    if (!store_log.exists(64'h6000)) begin
      errors++;
      $display("memory never received the merged store");
    end else begin
      check_value("store data at memory", store_log[64'h6000], 64'hcafe_f00d_0bad_c0de);
    end
    end_test("store merge");

    // slow memory so the queue backs up
    set_memory(1'b0, 6);
    full_seen = 1'b0;
    n = 0;
    while (!full_seen && n < 100) begin
      if (mshr_full) begin
        full_seen = 1'b1;
        next_cycle();
      end else begin
        for (int i = 0; i < 3; i++) begin
          stim_rng = lcg_next(stim_rng);
          set_slot(i, stim_rng[20] ? mem_bus_pkg::bus_store : mem_bus_pkg::bus_load,
                   {32'h0008_0000, stim_rng}, {~stim_rng, stim_rng});
        end
        stim_rng = lcg_next(stim_rng);
        launch(stim_rng[18:16]);
      end
      n++;
    end
    if (!full_seen) begin
      errors++;
      $display("queue never reported mshr_full under random traffic");
    end
    set_memory(1'b0, 1);
    drain(200);
    check_value("fill count", 64'(fill_rd), 64'(fill_wr));
    check_value("mshr_empty", 64'(mshr_empty), 64'd1);
    end_test("random traffic");

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== src.f ====
mem_bus_pkg.sv
mshr_pkg.sv
miss_order.sv
mshr_queue.sv
mshr_top.sv
tb_mshr.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mshr
FILELIST  = src.f
OBJ_DIR   = obj_dir

SRCS = $(shell grep -v '^+' $(FILELIST))
SIM  = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'PASS: all tests'

clean:
	rm -rf $(OBJ_DIR)
